//--- design/rv_bypass_if.sv
`timescale 1ns/100ps
`include "rv_params.svh"

interface rv_bypass_if;

    // Memory stage, newest result
    logic [4:0]          mem_rd;
    logic                mem_reg_write;
    logic [`RV_XLEN-1:0] mem_result;

    // Writeback stage, also the register file write port
    logic [4:0]          wb_rd;
    logic                wb_reg_write;
    logic [`RV_XLEN-1:0] wb_data;

    modport mem_side (
        output mem_rd, mem_reg_write, mem_result,
        output wb_rd, wb_reg_write, wb_data
    );

    modport use_side (
        input mem_rd, mem_reg_write, mem_result,
        input wb_rd, wb_reg_write, wb_data
    );

endinterface

//--- design/rv_cpu.sv
`timescale 1ns/100ps

module rv_cpu
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       load_en,    // Program load, only while enable is low
    input  imem_addr_t load_addr,
    input  word_t      load_data,
    output logic       wb_en,      // Writeback trace
    output reg_idx_t   wb_rd,
    output word_t      wb_data,
    output word_t      data_mem0
);

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    logic    redirect;
    word_t   redirect_pc;
    logic    flush;

    rv_bypass_if byp ();

    // ==============================
    // Pipeline stages
    // ==============================
    rv_fetch u_fetch (
        .clk, .rst, .enable, .load_en, .load_addr, .load_data,
        .redirect, .redirect_pc, .if_id
    );

    rv_decode u_decode (.clk, .rst, .flush, .if_id, .byp(byp.use_side), .id_ex);

    rv_execute u_execute (.clk, .rst, .flush, .id_ex, .byp(byp.use_side), .ex_mem);

    rv_mem_wb u_mem_wb (
        .clk, .rst, .ex_mem, .byp(byp.mem_side),
        .redirect, .redirect_pc, .flush, .data_mem0
    );

    // Trace is the register file write port
    assign wb_en   = byp.wb_reg_write;
    assign wb_rd   = byp.wb_rd;
    assign wb_data = byp.wb_data;

endmodule

//--- design/rv_decode.sv
`timescale 1ns/100ps

module rv_decode
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  if_id_t if_id,
    rv_bypass_if.use_side byp,
    output id_ex_t id_ex
);

    localparam logic [6:0] OP_R    = 7'b0110011;
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BR   = 7'b1100011;
    localparam logic [6:0] OP_JAL  = 7'b1101111;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    ctrl_t      ctrl;
    word_t      imm;
    word_t      regs [1:31];  // x0 is not stored

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // ==============================
    // Control decode
    // ==============================
    always_comb begin
        ctrl = '0;  // Unknown opcodes become bubbles
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin  // ADDI only
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = (funct3 == 3'b000);
            end
            OP_LOAD: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BR: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;  // Equal when difference is zero
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
        if (rd == '0) ctrl.reg_write = 1'b0;  // x0 never written
    end

    // ==============================
    // Immediate generation
    // ==============================
    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
            OP_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BR:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
            OP_JAL:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
            default:  imm = '0;
        endcase
    end

    // ==============================
    // Register file
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (byp.wb_reg_write && byp.wb_rd != '0) begin
            regs[byp.wb_rd] <= byp.wb_data;
        end
    end

    // Write-through so WB and ID can share a cycle
    function automatic word_t read_reg(reg_idx_t idx);
        word_t val;
        if (idx == '0) val = '0;
        else if (byp.wb_reg_write && byp.wb_rd == idx) val = byp.wb_data;
        else val = regs[idx];
        return val;
    endfunction

    // ID/EX register, only ctrl is cleared
    always_ff @(posedge clk) begin
        id_ex.pc       <= if_id.pc;
        id_ex.rs1_data <= read_reg(rs1);
        id_ex.rs2_data <= read_reg(rs2);
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        if (rst || flush) id_ex.ctrl <= '0;  // Wrong-path kill
        else id_ex.ctrl <= ctrl;
    end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  id_ex_t  id_ex,
    rv_bypass_if.use_side byp,
    output ex_mem_t ex_mem
);

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;  // Forwarded rs2
    word_t    alu_res;
    word_t    result;
    word_t    target;
    logic     zero;

    // ==============================
    // Forwarding unit
    // ==============================
    // Newest producer wins, MEM before WB
    function automatic fwd_sel_e pick_src(reg_idx_t rs);
        fwd_sel_e sel;
        if (rs != '0 && byp.mem_reg_write && byp.mem_rd == rs) sel = FWD_MEM;
        else if (rs != '0 && byp.wb_reg_write && byp.wb_rd == rs) sel = FWD_WB;
        else sel = FWD_REG;
        return sel;
    endfunction

    function automatic word_t pick_val(fwd_sel_e sel, word_t reg_val);
        word_t val;
        case (sel)
            FWD_MEM: val = byp.mem_result;
            FWD_WB:  val = byp.wb_data;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign sel_a      = pick_src(id_ex.rs1);
    assign sel_b      = pick_src(id_ex.rs2);
    assign op_a       = pick_val(sel_a, id_ex.rs1_data);
    assign store_data = pick_val(sel_b, id_ex.rs2_data);   // Also SW data
    assign op_b       = id_ex.ctrl.alu_src ? id_ex.imm : store_data;

    // ==============================
    // ALU and target adder
    // ==============================
    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    assign zero   = (alu_res == '0);                            // BEQ taken flag
    assign result = id_ex.ctrl.jump ? id_ex.pc + 32'd4 : alu_res;  // JAL link value
    assign target = id_ex.pc + id_ex.imm;

    // EX/MEM register
    always_ff @(posedge clk) begin
        ex_mem.target     <= target;
        ex_mem.zero       <= zero;
        ex_mem.result     <= result;
        ex_mem.store_data <= store_data;
        ex_mem.rd         <= id_ex.rd;
        if (rst || flush) ex_mem.ctrl <= '0;
        else ex_mem.ctrl <= id_ex.ctrl;
    end

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,       // Low holds the PC
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  word_t      load_data,
    input  logic       redirect,     // Taken branch or jump in MEM
    input  word_t      redirect_pc,
    output if_id_t     if_id
);

    localparam int IMEM_AW = $bits(imem_addr_t);

    word_t      pc;
    word_t      pc_next;
    imem_addr_t pc_idx;
    word_t      instr;
    word_t      imem [`RV_IMEM_DEPTH];

    // ==============================
    // Program counter
    // ==============================
    assign pc_next = redirect ? redirect_pc : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect || enable) begin  // Redirect lands even when paused
            pc <= pc_next;
        end
    end

    // ==============================
    // Instruction memory
    // ==============================
    always_ff @(posedge clk) begin
        if (load_en && !enable) begin  // Loading only while stopped
            imem[load_addr] <= load_data;
        end
    end

    assign pc_idx = pc[IMEM_AW+1:2];  // Word index
    assign instr  = imem[pc_idx];     // Async read

    // ==============================
    // IF/ID register
    // ==============================
    always_ff @(posedge clk) begin
        if_id.pc <= pc;
        if (rst || redirect || !enable) begin
            if_id.instr <= `RV_NOP;  // Bubble on flush or pause
        end else begin
            if_id.instr <= instr;
        end
    end

endmodule

//--- design/rv_mem_wb.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_mem_wb
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    rv_bypass_if.mem_side byp,
    output logic    redirect,
    output word_t   redirect_pc,
    output logic    flush,
    output word_t   data_mem0
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

    logic [DMEM_AW-1:0] addr;
    word_t              load_data;
    word_t              dmem [`RV_DMEM_DEPTH];
    // MEM/WB register
    reg_idx_t           rd_q;
    logic               reg_write_q;
    logic               mem_to_reg_q;
    word_t              load_q;
    word_t              result_q;

    // ==============================
    // Data memory
    // ==============================
    assign addr      = ex_mem.result[DMEM_AW+1:2];  // Word aligned
    assign load_data = dmem[addr];
    assign data_mem0 = dmem[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_DEPTH; i++) dmem[i] <= '0;
        end else if (ex_mem.ctrl.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    // Redirect resolves here
    assign redirect    = ex_mem.ctrl.jump || (ex_mem.ctrl.branch && ex_mem.zero);
    assign redirect_pc = ex_mem.target;
    assign flush       = redirect;  // Kills IF, ID and EX

    always_ff @(posedge clk) begin
        rd_q         <= ex_mem.rd;
        mem_to_reg_q <= ex_mem.ctrl.mem_to_reg;
        load_q       <= load_data;
        result_q     <= ex_mem.result;
        if (rst) reg_write_q <= 1'b0;
        else reg_write_q <= ex_mem.ctrl.reg_write;
    end

    // Bypass outputs
    assign byp.mem_rd        = ex_mem.rd;
    assign byp.mem_reg_write = ex_mem.ctrl.reg_write;
    assign byp.mem_result    = ex_mem.result;
    assign byp.wb_rd         = rd_q;
    assign byp.wb_reg_write  = reg_write_q;
    assign byp.wb_data       = mem_to_reg_q ? load_q : result_q;  // Writeback select

endmodule

//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path width
`define RV_XLEN 32

// Memory depths in words
`define RV_IMEM_DEPTH 64
`define RV_DMEM_DEPTH 64

// ADDI x0,x0,0 bubble
`define RV_NOP 32'h0000_0013

`endif

//--- design/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(`RV_IMEM_DEPTH)-1:0] imem_addr_t;  // Word address

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // Zero value, so a bubble adds
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    // All zero means bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;     // Immediate as operand b
        logic    branch;
        logic    jump;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;  // Load data to rd
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t    target;      // Branch or jump destination
        logic     zero;
        word_t    result;      // ALU result, pc+4 for jumps
        word_t    store_data;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } ex_mem_t;

endpackage

//--- files.f
+incdir+design
design/rv_pkg.sv
design/rv_bypass_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_wb.sv
design/rv_cpu.sv
verification/rv_properties.sv
verification/rv_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module rv_tb -o rv_sim || exit 1
./obj_dir/rv_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- verification/rv_properties.sv
`timescale 1ns/100ps

module rv_properties
    import rv_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     wb_en,
    input reg_idx_t wb_rd,
    input logic     redirect,
    input id_ex_t   id_ex,
    input ex_mem_t  ex_mem
);

    // Trace quiet right after reset
    wb_quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_en)
        else $error("wb_en high in the cycle after reset");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_rd != '0)
        else $error("writeback to x0 on the trace port");

    // Wrong path killed before EX and MEM
    flush_bubbles: assert property (@(posedge clk) disable iff (rst)
        redirect |=> (id_ex.ctrl == '0 && ex_mem.ctrl == '0))
        else $error("control word survived a redirect");

endmodule

bind rv_cpu rv_properties u_props (
    .clk, .rst, .wb_en, .wb_rd, .redirect, .id_ex, .ex_mem
);

//--- verification/rv_tb.sv
`timescale 1ns/100ps

module rv_tb
    import rv_pkg::*;
();

    localparam int PROG_LEN = 40;
    localparam int LAST     = PROG_LEN - 1;        // Index of the closing JAL x0,0
    localparam int LIMIT    = 10 * PROG_LEN + 50;  // Cycles allowed per run

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,   // R-type group, keep first
        K_ADDI, K_LW, K_SW, K_BEQ, K_JAL
    } kind_e;

    logic       clk = 1'b0;
    logic       rst;
    logic       enable;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    logic       wb_en;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    word_t      data_mem0;

    // Random program, abstract form plus encoding
    kind_e    p_kind [PROG_LEN];
    reg_idx_t p_rd   [PROG_LEN];
    reg_idx_t p_rs1  [PROG_LEN];
    reg_idx_t p_rs2  [PROG_LEN];
    word_t    p_imm  [PROG_LEN];  // Byte offset or immediate
    word_t    p_code [PROG_LEN];

    // Model output
    reg_idx_t exp_rd   [$];
    word_t    exp_val  [$];
    int       exp_test [$];       // Behavior a write belongs to
    word_t    exp_mem0;
    int       model_cycles;       // Issue slots incl. flush penalty
    int       errs [1:6];

    always #2 clk = ~clk;  // 4 ns

    rv_cpu UUT (
        .clk, .rst, .enable, .load_en, .load_addr, .load_data,
        .wb_en, .wb_rd, .wb_data, .data_mem0
    );

    // ==============================
    // Encoders
    // ==============================
    function automatic logic [9:0] r_funct(kind_e k);
        logic [9:0] f;
        case (k)
            K_SUB:   f = {7'b0100000, 3'b000};
            K_AND:   f = {7'b0000000, 3'b111};
            K_OR:    f = {7'b0000000, 3'b110};
            K_XOR:   f = {7'b0000000, 3'b100};
            K_SLT:   f = {7'b0000000, 3'b010};
            default: f = {7'b0000000, 3'b000};
        endcase
        return f;
    endfunction

    function automatic word_t enc_r(logic [9:0] f, reg_idx_t rs2, reg_idx_t rs1, reg_idx_t rd);
        return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2);  // Base x0
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs1, reg_idx_t rs2);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ==============================
    // Program generator
    // ==============================
    function automatic reg_idx_t pick_src(reg_idx_t avoid);
        reg_idx_t r;
        r = reg_idx_t'($urandom_range(1, 7));
        while (r == avoid) r = reg_idx_t'($urandom_range(1, 7));  // Load-use gap
        return r;
    endfunction

    function automatic word_t mem_offset();
        int slot;
        if ($urandom_range(0, 3) == 0) slot = 0;  // Favor word 0
        else slot = int'($urandom_range(0, 15));
        return word_t'(slot * 4);
    endfunction

    task automatic gen_program();
        reg_idx_t    avoid;
        int          roll;
        int          span;
        logic [11:0] imm12;
        avoid = 5'd0;
        for (int i = 0; i < LAST; i++) begin
            roll     = int'($urandom_range(0, 99));
            span     = (LAST - i < 4) ? LAST - i : 4;  // Targets stay inside
            p_rd[i]  = reg_idx_t'($urandom_range(1, 7));
            p_rs1[i] = pick_src(avoid);
            p_rs2[i] = pick_src(avoid);
            p_imm[i] = '0;
            if (roll < 45) begin
                p_kind[i] = kind_e'($urandom_range(0, 5));
                p_code[i] = enc_r(r_funct(p_kind[i]), p_rs2[i], p_rs1[i], p_rd[i]);
            end else if (roll < 65) begin
                p_kind[i] = K_ADDI;
                imm12     = 12'($urandom_range(0, 4095));
                p_imm[i]  = {{20{imm12[11]}}, imm12};
                p_code[i] = enc_i(imm12, p_rs1[i], 3'b000, p_rd[i], 7'b0010011);
            end else if (roll < 75) begin
                p_kind[i] = K_LW;
                p_rs1[i]  = 5'd0;
                p_imm[i]  = mem_offset();
                p_code[i] = enc_i(p_imm[i][11:0], 5'd0, 3'b010, p_rd[i], 7'b0000011);
            end else if (roll < 85) begin
                p_kind[i] = K_SW;
                p_rs1[i]  = 5'd0;
                p_imm[i]  = mem_offset();
                p_code[i] = enc_s(p_imm[i][11:0], p_rs2[i]);
            end else if (roll < 94) begin
                p_kind[i] = K_BEQ;
                if ($urandom_range(0, 1) == 1) p_rs2[i] = p_rs1[i];  // Surely taken
                p_imm[i]  = word_t'($urandom_range(1, span)) * 4;
                p_code[i] = enc_b(p_imm[i][12:0], p_rs1[i], p_rs2[i]);
            end else begin
                p_kind[i] = K_JAL;
                p_imm[i]  = word_t'($urandom_range(1, span)) * 4;
                p_code[i] = enc_j(p_imm[i][20:0], p_rd[i]);
            end
            avoid = (p_kind[i] == K_LW) ? p_rd[i] : 5'd0;
        end
        p_kind[LAST] = K_JAL;  // Park forever, no write
        p_rd[LAST]   = 5'd0;
        p_rs1[LAST]  = 5'd0;
        p_rs2[LAST]  = 5'd0;
        p_imm[LAST]  = '0;
        p_code[LAST] = enc_j(21'd0, 5'd0);
    endtask

    // ==============================
    // ISA model
    // ==============================
    task automatic run_model();
        word_t regs [32];
        word_t mem [16];
        word_t a;
        word_t b;
        word_t val;
        bit    wr;
        int    pc;
        foreach (regs[r]) regs[r] = '0;
        foreach (mem[m]) mem[m] = '0;
        pc           = 0;
        model_cycles = 0;
        val          = '0;
        while (pc != LAST) begin
            a  = regs[p_rs1[pc]];
            b  = regs[p_rs2[pc]];
            wr = 1'b1;
            model_cycles++;
            case (p_kind[pc])
                K_ADD:  val = a + b;
                K_SUB:  val = a - b;
                K_AND:  val = a & b;
                K_OR:   val = a | b;
                K_XOR:  val = a ^ b;
                K_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: val = a + p_imm[pc];
                K_LW:   val = mem[p_imm[pc][5:2]];
                K_SW: begin
                    mem[p_imm[pc][5:2]] = b;
                    wr = 1'b0;
                end
                K_BEQ:  wr = 1'b0;
                default: val = word_t'(pc * 4 + 4);  // JAL link
            endcase
            if (wr) begin
                regs[p_rd[pc]] = val;
                exp_rd.push_back(p_rd[pc]);
                exp_val.push_back(val);
                if (p_kind[pc] == K_LW) exp_test.push_back(3);
                else if (p_kind[pc] == K_JAL) exp_test.push_back(4);
                else exp_test.push_back(2);
            end
            if (p_kind[pc] == K_JAL || (p_kind[pc] == K_BEQ && a == b)) begin
                model_cycles += 3;  // Three wrong-path slots
                pc = pc + int'(p_imm[pc] >> 2);
            end else begin
                pc++;
            end
        end
        exp_mem0 = mem[0];
    endtask

    // ==============================
    // Checks and stimulus
    // ==============================
    task automatic compare_word(input int test, input string name, input word_t got,
                                input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            errs[test]++;
        end
    endtask

    task automatic compare_reg(input int test, input string name, input reg_idx_t got,
                               input reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got x%0d, expected x%0d", $time, name, got, exp);
            errs[test]++;
        end
    endtask

    task automatic check_idle();
        if (wb_en !== 1'b0) begin
            $display("Writeback active at %0t before any instruction ran", $time);
            errs[1]++;
        end
        compare_word(1, "data_mem0", data_mem0, '0);
    endtask

    task automatic apply_reset();
        rst    = 1'b1;
        enable = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            check_idle();
            load_en   = 1'b1;
            load_addr = imem_addr_t'(i);
            load_data = p_code[i];
        end
        @(negedge clk);
        check_idle();
        load_en = 1'b0;
    endtask

    task automatic run_program(input bit pauses);
        int cycle;
        int idx;
        int quiet;
        int en_cycles;
        int hold;
        int test;
        bit done;
        cycle     = 0;
        idx       = 0;
        quiet     = 0;
        hold      = 0;
        done      = 1'b0;
        enable    = 1'b1;  // Fetch from pc 0
        en_cycles = 1;
        while (!done && cycle < LIMIT) begin
            @(negedge clk);
            cycle++;
            if (wb_en !== 1'b0) begin
                if (idx < exp_rd.size()) begin
                    test = pauses ? 5 : exp_test[idx];
                    compare_reg(test, "wb_rd", wb_rd, exp_rd[idx]);
                    compare_word(test, "wb_data", wb_data, exp_val[idx]);
                    idx++;
                end else begin
                    $display("Extra write to x%0d at %0t after the last expected one",
                             wb_rd, $time);
                    errs[pauses ? 5 : 6]++;
                end
            end
            if (idx == exp_rd.size()) quiet++;
            done = (quiet > 20) && (en_cycles >= model_cycles + 8);
            if (!pauses) begin
                enable = 1'b1;
            end else if (hold > 0) begin
                hold--;
                enable = 1'b0;
            end else if ($urandom_range(0, 5) == 0) begin
                hold   = int'($urandom_range(0, 3));  // 1 to 4 cycles low
                enable = 1'b0;
            end else begin
                enable = 1'b1;
            end
            if (enable) en_cycles++;
        end
        enable = 1'b0;
        if (!done) begin
            $display("Timeout after %0d cycles with %0d of %0d writes seen",
                     cycle, idx, exp_rd.size());
            errs[pauses ? 5 : 6]++;
        end
        compare_word(pauses ? 5 : 3, "data_mem0", data_mem0, exp_mem0);
    endtask

    task automatic report(input int test, input string label);
        if (errs[test] == 0) $display("Test %0d %s: PASS", test, label);
        else $display("Test %0d %s: FAIL with %0d errors", test, label, errs[test]);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int passed;
        int total;
        rst       = 1'b1;
        enable    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        foreach (errs[t]) errs[t] = 0;
        void'($urandom(32'h8756_61e6));
        gen_program();
        run_model();
        apply_reset();
        load_program();          // Pipeline idle meanwhile
        report(1, "reset");
        run_program(1'b0);
        report(2, "ALU and forwarding");
        report(3, "memory");
        report(4, "branches and jumps");
        report(6, "drain");
        apply_reset();           // Program memory survives reset
        run_program(1'b1);
        report(5, "enable pauses");
        passed = 0;
        total  = 0;
        for (int t = 1; t <= 6; t++) begin
            if (errs[t] == 0) passed++;
            total += errs[t];
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, 6 - passed, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
